//--- hdl/acq_params.svh
// Build-time sizes and latencies of the ADC capture engine.
// Included by the shared package and by every RTL file that needs a width.

`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// Significant ADC bits, left-adjusted inside a wider stream slot
`define ADC_WIDTH 14
`define SAMPLE_WIDTH 16

// Samples delivered on each adcClk cycle
`define SAMPLES_PER_FRAME 2

// Capture depth in frames and number of external trigger lines
`define BUFFER_FRAMES 64
`define EVENT_LINES 4

// Cycles from the detector frame register to its trigger hit
`define TRIGGER_LATENCY 3

// Wishbone word address width
`define WB_ADDR_WIDTH 8

`endif

//--- hdl/acqPkg.sv
// Types shared by the capture engine blocks and the testbench.
// Sizes come from the parameter header.

`include "acq_params.svh"

package acqPkg;

    // One ADC conversion with the slot padding removed
    typedef logic signed [`ADC_WIDTH-1:0] adcSample_t;

    // All samples of one clock, one buffer word
    typedef adcSample_t [`SAMPLES_PER_FRAME-1:0] sampleFrame_t;

    // Frame index into the circular buffer
    typedef logic [$clog2(`BUFFER_FRAMES)-1:0] bufferAddr_t;

    // Sample position inside a frame
    typedef logic [$clog2(`SAMPLES_PER_FRAME)-1:0] laneIndex_t;

    // Wide enough to hold a full buffer of frames
    typedef logic [$clog2(`BUFFER_FRAMES):0] frameCount_t;

    typedef logic [`EVENT_LINES-1:0] eventMask_t;

    // Capture sequence, Idle must stay at zero for the status register
    typedef enum logic [2:0] {
        Idle,
        Fill,
        Armed,
        Acquire,
        Done
    } acqState_e;

endpackage

//--- hdl/acqControlIf.sv
// Control bundle between the register bank, trigger detector and sequencer.
// Carries configuration, arming and the trigger result.

`timescale 1ns/1ps

interface acqControlIf;
    import acqPkg::*;

    // Configuration from the register bank
    adcSample_t  triggerLevel;
    logic        fallingEdge;
    eventMask_t  eventEnables;
    frameCount_t pretriggerFrames;
    logic        armPulse;

    // Sequencer status
    logic        watch;
    acqState_e   state;
    bufferAddr_t triggerAddress;
    laneIndex_t  triggerLane;
    logic        donePulse;

    // Detector result
    logic        triggerHit;
    laneIndex_t  hitLane;

    modport registers (
        output triggerLevel, fallingEdge, eventEnables, pretriggerFrames, armPulse,
        input  state, triggerAddress, triggerLane, donePulse
    );
    modport detector (
        input  triggerLevel, fallingEdge, eventEnables, watch,
        output triggerHit, hitLane
    );
    modport sequencer (
        input  pretriggerFrames, armPulse, triggerHit, hitLane,
        output watch, state, triggerAddress, triggerLane, donePulse
    );
endinterface

//--- hdl/wbRegisterBank.sv
// Wishbone classic slave for trigger setup, arming, status and sample readback.
// Every access is acknowledged on the cycle after the request is seen.

`timescale 1ns/1ps
`include "acq_params.svh"

module wbRegisterBank (
    input  logic                      adcClk,
    input  logic                      reset,
    input  logic                      wbCyc,
    input  logic                      wbStb,
    input  logic                      wbWe,
    input  logic [`WB_ADDR_WIDTH-1:0] wbAdr,
    input  logic [31:0]               wbDatW,
    output logic [31:0]               wbDatR,
    output logic                      wbAck,
    acqControlIf.registers            ctrl,
    output acqPkg::bufferAddr_t       readAddress,
    input  acqPkg::sampleFrame_t      readFrame
);
    import acqPkg::*;

    localparam int AddrBits = $bits(bufferAddr_t);
    localparam int LaneBits = $bits(laneIndex_t);
    localparam int CountBits = $bits(frameCount_t);
    // Level slot, event enables, falling edge flag
    localparam int Config1Width = `SAMPLE_WIDTH + `EVENT_LINES + 1;

    localparam logic [`WB_ADDR_WIDTH-1:0] StatusAddr = 0;
    localparam logic [`WB_ADDR_WIDTH-1:0] ConfigAddr = 1;
    localparam logic [`WB_ADDR_WIDTH-1:0] PretriggerAddr = 2;
    localparam logic [`WB_ADDR_WIDTH-1:0] LocationAddr = 3;

    logic                    request;
    logic                    writeAccess;
    logic                    armWrite;
    logic                    active;
    logic                    full;
    logic [Config1Width-1:0] config1;
    laneIndex_t              sampleLane;

    // Ack blocks the held request from being taken a second time
    assign request = wbCyc && wbStb && !wbAck;
    assign writeAccess = request && wbWe;
    assign armWrite = writeAccess && (wbAdr == StatusAddr) && wbDatW[0];

    assign ctrl.triggerLevel = adcSample_t'(config1[`SAMPLE_WIDTH-1 -: `ADC_WIDTH]);
    assign ctrl.eventEnables = config1[`SAMPLE_WIDTH +: `EVENT_LINES];
    assign ctrl.fallingEdge = config1[Config1Width-1];

    // Sample window at the top half of the map, two samples per frame
    assign readAddress = wbAdr[LaneBits +: AddrBits];
    assign sampleLane = wbAdr[LaneBits-1:0];

    always_ff @(posedge adcClk) begin
        if (reset) begin
            wbAck <= 1'b0;
            ctrl.armPulse <= 1'b0;
            active <= 1'b0;
            full <= 1'b0;
            config1 <= '0;
            ctrl.pretriggerFrames <= '0;
        end else begin
            wbAck <= request;
            ctrl.armPulse <= armWrite;
            if (writeAccess && (wbAdr == ConfigAddr)) begin
                config1 <= wbDatW[Config1Width-1:0];
            end
            if (writeAccess && (wbAdr == PretriggerAddr)) begin
                ctrl.pretriggerFrames <= wbDatW[CountBits-1:0];
            end
            // A pending arm restarts the sequencer, so it outranks completion
            if (armWrite) begin
                active <= 1'b1;
                full <= 1'b0;
            end else if (ctrl.donePulse && !ctrl.armPulse) begin
                active <= 1'b0;
                full <= 1'b1;
            end
        end
    end

    // Buffer output is registered, so the sample is ready in the ack cycle
    always_comb begin
        wbDatR = '0;
        if (wbAdr[`WB_ADDR_WIDTH-1]) begin
            wbDatR[`SAMPLE_WIDTH-1 -: `ADC_WIDTH] = readFrame[sampleLane];
        end else begin
            case (wbAdr)
                StatusAddr: begin
                    wbDatR[31] = active;
                    wbDatR[30] = full;
                    wbDatR[$bits(acqState_e)-1:0] = ctrl.state;
                end
                ConfigAddr:     wbDatR[Config1Width-1:0] = config1;
                PretriggerAddr: wbDatR[CountBits-1:0] = ctrl.pretriggerFrames;
                LocationAddr:   wbDatR[AddrBits+LaneBits-1:0] = {ctrl.triggerAddress,
                                                                 ctrl.triggerLane};
                default: ;
            endcase
        end
    end

    ackSingleCycle: assert property (@(posedge adcClk) disable iff (reset)
        wbAck |=> !wbAck);

endmodule

//--- hdl/triggerDetector.sv
// Extracts samples from the stream and looks for a level or event trigger.
// The frame goes on to the sequencer; hits go out through the control bundle.

`timescale 1ns/1ps
`include "acq_params.svh"

module triggerDetector (
    input  logic                                      adcClk,
    input  logic                                      reset,
    input  logic                                      axiValid,
    input  logic [`SAMPLES_PER_FRAME*`SAMPLE_WIDTH-1:0] axiData,
    input  acqPkg::eventMask_t                        eventStrobes,
    acqControlIf.detector                             ctrl,
    output logic                                      frameValid,
    output acqPkg::sampleFrame_t                      frame
);
    import acqPkg::*;

    localparam int Lanes = `SAMPLES_PER_FRAME;
    localparam int AdcShift = `SAMPLE_WIDTH - `ADC_WIDTH;

    logic [Lanes-1:0] above;
    logic [Lanes-1:0] below;
    logic [Lanes-1:0] selectedFlags;
    logic [Lanes-1:0] laneFlags;
    logic             beenIdle;
    logic             hitTaken;
    logic             eventHit;
    logic             levelHit;
    laneIndex_t       lowestLane;

    always_ff @(posedge adcClk) begin
        for (int i = 0; i < Lanes; i++) begin
            frame[i] <= axiData[i*`SAMPLE_WIDTH + AdcShift +: `ADC_WIDTH];
            above[i] <= frame[i] > ctrl.triggerLevel;
            below[i] <= frame[i] < ctrl.triggerLevel;
        end
        laneFlags <= selectedFlags;
        ctrl.hitLane <= eventHit ? '0 : lowestLane;
    end

    assign selectedFlags = ctrl.fallingEdge ? below : above;
    assign eventHit = |(ctrl.eventEnables & eventStrobes);
    // Idle frame must have been flagged ahead of the crossing frame
    assign levelHit = beenIdle && (|laneFlags);

    // Earliest sample in the frame wins
    always_comb begin
        lowestLane = '0;
        for (int i = Lanes - 1; i >= 0; i--) begin
            if (laneFlags[i]) begin
                lowestLane = laneIndex_t'(i);
            end
        end
    end

    always_ff @(posedge adcClk) begin
        if (reset) begin
            frameValid <= 1'b0;
            beenIdle <= 1'b0;
            hitTaken <= 1'b0;
            ctrl.triggerHit <= 1'b0;
        end else begin
            frameValid <= axiValid;
            ctrl.triggerHit <= 1'b0;
            if (!ctrl.watch) begin
                beenIdle <= 1'b0;
                hitTaken <= 1'b0;
            end else begin
                if (selectedFlags == '0) begin
                    beenIdle <= 1'b1;
                end
                // One hit per watch window
                if (!hitTaken && (eventHit || levelHit)) begin
                    ctrl.triggerHit <= 1'b1;
                    hitTaken <= 1'b1;
                end
            end
        end
    end

    hitOnlyWhileWatching: assert property (@(posedge adcClk) disable iff (reset)
        ctrl.triggerHit |-> ctrl.watch);

endmodule

//--- hdl/captureSequencer.sv
// Capture FSM: fills the pretrigger history, waits for a hit, then
// writes the posttrigger frames into the circular buffer.

`timescale 1ns/1ps
`include "acq_params.svh"

module captureSequencer (
    input  logic                 adcClk,
    input  logic                 reset,
    input  logic                 frameValid,
    input  acqPkg::sampleFrame_t frame,
    acqControlIf.sequencer       ctrl,
    output logic                 writeEnable,
    output acqPkg::bufferAddr_t  writeAddress,
    output acqPkg::sampleFrame_t writeFrame
);
    import acqPkg::*;

    // Trigger frame plus the frames behind it in the detector are already written
    localparam int PostOverhead = `TRIGGER_LATENCY + 1;

    acqState_e   state;
    frameCount_t fillRemaining;
    frameCount_t postRemaining;
    frameCount_t postLoad;
    logic        armAccepted;

    assign ctrl.state = state;
    assign ctrl.donePulse = (state == Done);
    assign writeFrame = frame;
    assign armAccepted = ctrl.armPulse && ((state == Idle) || (state == Done));

    always_comb begin
        if (int'(ctrl.pretriggerFrames) + PostOverhead < `BUFFER_FRAMES) begin
            postLoad = frameCount_t'(`BUFFER_FRAMES - PostOverhead -
                                     int'(ctrl.pretriggerFrames));
        end else begin
            postLoad = '0;
        end
    end

    always_comb begin
        case (state)
            Fill, Armed: writeEnable = frameValid;
            Acquire:     writeEnable = frameValid && (postRemaining != '0);
            default:     writeEnable = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State machine and write addressing

    always_ff @(posedge adcClk) begin
        if (reset) begin
            state <= Idle;
            ctrl.watch <= 1'b0;
            writeAddress <= '0;
            fillRemaining <= '0;
            postRemaining <= '0;
        end else begin
            if (writeEnable) begin
                writeAddress <= writeAddress + 1'b1;
            end
            case (state)
                Idle, Done: begin
                    state <= armAccepted ? Fill : Idle;
                    fillRemaining <= ctrl.pretriggerFrames;
                end
                Fill: begin
                    if (fillRemaining == '0) begin
                        state <= Armed;
                        ctrl.watch <= 1'b1;
                    end else if (frameValid) begin
                        fillRemaining <= fillRemaining - 1'b1;
                    end
                end
                Armed: begin
                    if (ctrl.triggerHit) begin
                        state <= Acquire;
                        ctrl.watch <= 1'b0;
                        // Frame that held the triggering sample
                        ctrl.triggerAddress <= writeAddress -
                                               bufferAddr_t'(`TRIGGER_LATENCY);
                        ctrl.triggerLane <= ctrl.hitLane;
                        postRemaining <= postLoad;
                    end
                end
                Acquire: begin
                    if (postRemaining == '0) begin
                        state <= Done;
                    end else if (frameValid) begin
                        postRemaining <= postRemaining - 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    noWriteWhenIdle: assert property (@(posedge adcClk) disable iff (reset)
        (state == Idle) |-> !writeEnable);
    doneIsPulse: assert property (@(posedge adcClk) disable iff (reset)
        ctrl.donePulse |=> !ctrl.donePulse);

endmodule

//--- hdl/frameBuffer.sv
// Circular capture memory, one frame per word.
// Written by the sequencer, read back through the register bank.

`timescale 1ns/1ps
`include "acq_params.svh"

module frameBuffer (
    input  logic                 adcClk,
    input  logic                 writeEnable,
    input  acqPkg::bufferAddr_t  writeAddress,
    input  acqPkg::sampleFrame_t writeFrame,
    input  acqPkg::bufferAddr_t  readAddress,
    output acqPkg::sampleFrame_t readFrame
);
    import acqPkg::*;

    sampleFrame_t memory [`BUFFER_FRAMES];

    // Write port
    always_ff @(posedge adcClk) begin
        if (writeEnable) begin
            memory[writeAddress] <= writeFrame;
        end
    end

    // Registered read port, maps onto block RAM output register
    always_ff @(posedge adcClk) begin
        readFrame <= memory[readAddress];
    end

endmodule

//--- hdl/acquisitionTop.sv
// ADC capture engine top level with plain stream, event and Wishbone ports.
// Everything runs on adcClk.

`timescale 1ns/1ps
`include "acq_params.svh"

module acquisitionTop (
    input  logic                                        adcClk,
    input  logic                                        reset,
    input  logic                                        axiValid,
    input  logic [`SAMPLES_PER_FRAME*`SAMPLE_WIDTH-1:0] axiData,
    input  acqPkg::eventMask_t                          eventStrobes,
    input  logic                                        wbCyc,
    input  logic                                        wbStb,
    input  logic                                        wbWe,
    input  logic [`WB_ADDR_WIDTH-1:0]                   wbAdr,
    input  logic [31:0]                                 wbDatW,
    output logic [31:0]                                 wbDatR,
    output logic                                        wbAck
);
    import acqPkg::*;

    acqControlIf ctrl ();

    logic         frameValid;
    sampleFrame_t frame;
    logic         writeEnable;
    bufferAddr_t  writeAddress;
    sampleFrame_t writeFrame;
    bufferAddr_t  readAddress;
    sampleFrame_t readFrame;

    triggerDetector trigDetector (.adcClk, .reset, .axiValid, .axiData, .eventStrobes,
        .ctrl(ctrl), .frameValid, .frame);

    captureSequencer capSequencer (.adcClk, .reset, .frameValid, .frame, .ctrl(ctrl),
        .writeEnable, .writeAddress, .writeFrame);

    frameBuffer frameRam (.adcClk, .writeEnable, .writeAddress, .writeFrame,
        .readAddress, .readFrame);

    wbRegisterBank regBank (.adcClk, .reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
        .wbDatR, .wbAck, .ctrl(ctrl), .readAddress, .readFrame);

endmodule

//--- verification/acqTb.sv
// Testbench for the ADC capture engine: ramp stream, Wishbone access and trigger checks.
// Compile with tb.f and run acqTb as the top module.

`timescale 1ns/1ps
`include "acq_params.svh"

module acqTb;
    import acqPkg::*;

    localparam int RampFrames = (1 << `ADC_WIDTH) / `SAMPLES_PER_FRAME;
    localparam int Captures = 4;
    localparam int CycleLimit = 3 * Captures * (`BUFFER_FRAMES + RampFrames);
    localparam int TestCount = 5;

    logic                                        adcClk;
    logic                                        reset;
    logic                                        axiValid;
    logic [`SAMPLES_PER_FRAME*`SAMPLE_WIDTH-1:0] axiData;
    eventMask_t                                  eventStrobes;
    logic                                        wbCyc;
    logic                                        wbStb;
    logic                                        wbWe;
    logic [`WB_ADDR_WIDTH-1:0]                   wbAdr;
    logic [31:0]                                 wbDatW;
    logic [31:0]                                 wbDatR;
    logic                                        wbAck;

    // Ramp model, sample n is baseValue + direction * (n - baseIndex)
    longint     streamIndex;
    longint     baseIndex;
    adcSample_t baseValue;
    int         direction;
    logic       reverseRequest;

    logic [31:0] rdata;
    int          errorCount;
    int          failedTests;
    int          cycleCount = 0;

    acquisitionTop i_dut (.adcClk, .reset, .axiValid, .axiData, .eventStrobes, .wbCyc, .wbStb,
        .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck);

    initial begin
        adcClk = 1'b0;
        forever #50 adcClk = ~adcClk;
    end

    always @(posedge adcClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles, a capture never reported full", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic adcSample_t rampAt(input longint index);
        return adcSample_t'(longint'(baseValue) + direction * (index - baseIndex));
    endfunction

    // First flagged sample that follows a frame with no flagged sample
    function automatic longint findTrigger(input longint start, input adcSample_t level,
                                           input logic falling);
        logic idleSeen;
        logic frameFlagged;
        logic flagged;
        idleSeen = 1'b0;
        for (longint n = start; n < start + 4 * (1 << `ADC_WIDTH); n += `SAMPLES_PER_FRAME) begin
            frameFlagged = 1'b0;
            for (int i = 0; i < `SAMPLES_PER_FRAME; i++) begin
                flagged = falling ? (rampAt(n + i) < level) : (rampAt(n + i) > level);
                if (flagged && idleSeen) begin
                    return n + i;
                end
                frameFlagged |= flagged;
            end
            if (!frameFlagged) begin
                idleSeen = 1'b1;
            end
        end
        return -1;
    endfunction

    // Level a few hundred samples ahead of the ramp, clear of the wrap point
    function automatic adcSample_t chooseLevel(input adcSample_t current, input logic falling);
        if (!falling) begin
            return (current > -7500 && current < 7000) ? current + 300 : -7000;
        end
        return (current > -7000 && current < 7500) ? current - 300 : 7000;
    endfunction

    // Stream driver, reversal takes effect on the next frame
    always @(negedge adcClk) begin
        if (reverseRequest) begin
            baseValue = adcSample_t'(rampAt(streamIndex - 1) - direction);
            baseIndex = streamIndex;
            direction = -direction;
            reverseRequest = 1'b0;
        end
        for (int i = 0; i < `SAMPLES_PER_FRAME; i++) begin
            axiData[i*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] =
                {rampAt(streamIndex + i), {(`SAMPLE_WIDTH - `ADC_WIDTH){1'b0}}};
        end
        streamIndex = streamIndex + `SAMPLES_PER_FRAME;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus access and compare tasks

    task automatic wbAccess(input logic write, input logic [`WB_ADDR_WIDTH-1:0] adr,
                            input logic [31:0] data, output logic [31:0] readData);
        @(negedge adcClk);
        if (wbAck !== 1'b0) begin
            $display("Ack still high at %0t before a new request", $time);
            errorCount++;
        end
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = write;
        wbAdr = adr;
        wbDatW = data;
        @(negedge adcClk);
        if (wbAck !== 1'b1) begin
            $display("No ack one cycle after the request to address %0d at %0t", adr, $time);
            errorCount++;
        end
        readData = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkSample(input string name, input adcSample_t expected,
                               input adcSample_t actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkLane(input string name, input laneIndex_t expected,
                             input laneIndex_t actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic waitForFull();
        rdata = '0;
        while (!rdata[30]) begin
            wbAccess(1'b0, 0, 0, rdata);
        end
        checkWord("status", 32'h4000_0000, rdata);
    endtask

    task automatic checkWindow(input bufferAddr_t startFrame, input longint firstIndex);
        adcSample_t  sample;
        bufferAddr_t frameAddr;
        for (int k = 0; k < `BUFFER_FRAMES * `SAMPLES_PER_FRAME; k++) begin
            frameAddr = startFrame + bufferAddr_t'(k / `SAMPLES_PER_FRAME);
            wbAccess(1'b0, {1'b1, frameAddr, laneIndex_t'(k % `SAMPLES_PER_FRAME)}, 0, rdata);
            sample = adcSample_t'(rdata[`SAMPLE_WIDTH-1 -: `ADC_WIDTH]);
            checkSample($sformatf("window[%0d]", k), rampAt(firstIndex + k), sample);
        end
    endtask

    task automatic levelCapture(input logic falling, input int pretrigger);
        adcSample_t level;
        longint     trigIndex;
        laneIndex_t lane;
        @(posedge adcClk);
        level = chooseLevel(rampAt(streamIndex), falling);
        wbAccess(1'b1, 1, 32'({falling, eventMask_t'(0), level, 2'b00}), rdata);
        wbAccess(1'b1, 2, pretrigger, rdata);
        @(posedge adcClk);
        trigIndex = findTrigger(streamIndex, level, falling);
        lane = laneIndex_t'(trigIndex % `SAMPLES_PER_FRAME);
        wbAccess(1'b1, 0, 1, rdata);
        waitForFull();
        wbAccess(1'b0, 3, 0, rdata);
        checkLane("triggerLane", lane, laneIndex_t'(rdata[0]));
        checkWindow(bufferAddr_t'(rdata[$bits(laneIndex_t) +: $bits(bufferAddr_t)] - pretrigger),
                    trigIndex - lane - pretrigger * `SAMPLES_PER_FRAME);
        wbAccess(1'b0, 3, 0, rdata);
        wbAccess(1'b0, {1'b1, rdata[$bits(bufferAddr_t)+$bits(laneIndex_t)-1:0]}, 0, rdata);
        checkSample("triggerSample", rampAt(trigIndex),
                    adcSample_t'(rdata[`SAMPLE_WIDTH-1 -: `ADC_WIDTH]));
    endtask

    task automatic eventCapture(input int line, input int pretrigger);
        longint trigIndex;
        wbAccess(1'b1, 1, 32'({1'b0, eventMask_t'(1 << line), 16'h7FFC}), rdata);
        wbAccess(1'b1, 2, pretrigger, rdata);
        wbAccess(1'b1, 0, 1, rdata);
        wbAccess(1'b0, 0, 0, rdata);
        checkWord("status.activeFull", 32'h8000_0000, rdata & 32'hC000_0000);
        while (rdata[2:0] != 3'(Armed)) begin
            wbAccess(1'b0, 0, 0, rdata);
        end
        // Let the pretrigger history settle behind the trigger frame
        repeat (8) @(negedge adcClk);
        eventStrobes[line] = 1'b1;
        @(posedge adcClk);
        // Reported frame lies the detector latency behind the frame seen with the strobe
        trigIndex = streamIndex - (`TRIGGER_LATENCY + 1) * `SAMPLES_PER_FRAME;
        @(negedge adcClk);
        eventStrobes = '0;
        waitForFull();
        wbAccess(1'b0, 3, 0, rdata);
        checkLane("triggerLane", '0, laneIndex_t'(rdata[0]));
        checkWindow(bufferAddr_t'(rdata[$bits(laneIndex_t) +: $bits(bufferAddr_t)] - pretrigger),
                    trigIndex - pretrigger * `SAMPLES_PER_FRAME);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errorCount - errorsBefore);
            failedTests++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          errorsBefore;
        logic [31:0] word;
        void'($urandom(32'h1773_1e71));
        reset = 1'b1;
        axiValid = 1'b0;
        axiData = '0;
        eventStrobes = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        streamIndex = 0;
        baseIndex = 0;
        baseValue = adcSample_t'($urandom);
        direction = 1;
        reverseRequest = 1'b0;
        errorCount = 0;
        failedTests = 0;
        repeat (8) @(negedge adcClk);
        reset = 1'b0;
        axiValid = 1'b1;

        errorsBefore = errorCount;
        wbAccess(1'b0, 0, 0, rdata);
        checkWord("status", 32'h0, rdata);
        word = $urandom & ((1 << (`SAMPLE_WIDTH + `EVENT_LINES + 1)) - 1);
        wbAccess(1'b1, 1, word, rdata);
        wbAccess(1'b0, 1, 0, rdata);
        checkWord("config", word, rdata);
        word = $urandom & ((1 << $bits(frameCount_t)) - 1);
        wbAccess(1'b1, 2, word, rdata);
        wbAccess(1'b0, 2, 0, rdata);
        checkWord("pretrigger", word, rdata);
        finishTest("register access", errorsBefore);

        errorsBefore = errorCount;
        levelCapture(1'b0, 12);
        finishTest("rising trigger and window", errorsBefore);

        // Turn the ramp around so a falling crossing follows
        errorsBefore = errorCount;
        @(posedge adcClk);
        reverseRequest = 1'b1;
        repeat (4) @(posedge adcClk);
        levelCapture(1'b1, 20);
        finishTest("falling trigger and window", errorsBefore);

        errorsBefore = errorCount;
        eventCapture(2, 10);
        finishTest("event trigger", errorsBefore);

        errorsBefore = errorCount;
        eventCapture(0, 30);
        finishTest("re-arm", errorsBefore);

        $display("Tests run %0d, failed %0d, check errors %0d", TestCount, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/acqPkg.sv
hdl/acqControlIf.sv
hdl/wbRegisterBank.sv
hdl/triggerDetector.sv
hdl/captureSequencer.sv
hdl/frameBuffer.sv
hdl/acquisitionTop.sv
verification/acqTb.sv
